// ==== rtl/realign_pkg.sv ====
// fixed 64-bit word of 8 bytes; line lengths of 1 to 255 output words, zero is not supported

package realign_pkg;

  // word geometry
  localparam int unsigned DATA_W = 64;
  localparam int unsigned STRB_W = DATA_W / 8;

  // byte offset and line length widths
  localparam int unsigned OFF_W = $clog2(STRB_W);
  localparam int unsigned LEN_W = 8;

  // one data beat on any of the streams
  typedef logic [DATA_W-1:0] word_t;

  // first valid byte of a line inside its first input word
  typedef logic [OFF_W-1:0] off_t;

  // line length in aligned output words
  typedef logic [LEN_W-1:0] len_t;

endpackage : realign_pkg

// ==== rtl/stream_fifo.sv ====
// FIFO_DEPTH must be 2 or more; no bypass path, so a word is seen at the output one cycle after push

module stream_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                push_valid_i,
  output logic                push_ready_o,
  input  realign_pkg::word_t  push_data_i,
  output logic                pop_valid_o,
  input  logic                pop_ready_i,
  output realign_pkg::word_t  pop_data_o
);

  import realign_pkg::*;

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  word_t             mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              push;
  logic              pop;

  assign push_ready_o = (count_q != CNT_W'(FIFO_DEPTH));
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  // pointers wrap by hand so that depths other than powers of two work
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        if (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + PTR_W'(1);
        end
      end
      if (pop) begin
        if (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + PTR_W'(1);
        end
      end
      // simultaneous push and pop leave the fill level unchanged
      if (push && !pop) begin
        count_q <= count_q + CNT_W'(1);
      end else if (pop && !push) begin
        count_q <= count_q - CNT_W'(1);
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule : stream_fifo

// ==== rtl/line_sequencer.sv ====
// one line at a time; a command is taken only when idle, and a length of zero is not supported

module line_sequencer (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               cmd_valid_i,
  output logic               cmd_ready_o,
  input  realign_pkg::off_t  cmd_offset_i,
  input  realign_pkg::len_t  cmd_length_i,
  input  logic               beat_take_i,
  output logic               line_active_o,
  output realign_pkg::off_t  line_rot_o,
  output logic               beat_first_o,
  output logic               beat_last_o
);

  import realign_pkg::*;

  // one spare bit, a misaligned line needs length plus one input beats
  localparam int unsigned CNT_W = LEN_W + 1;

  typedef enum logic {
    IDLE,
    RUN
  } state_e;

  state_e            state_q;
  off_t              rot_q;
  logic [CNT_W-1:0]  beats_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [CNT_W-1:0]  cmd_beats;
  logic              cmd_accept;

  assign cmd_ready_o = (state_q == IDLE);
  assign cmd_accept  = cmd_valid_i & cmd_ready_o;

  // input beats for the incoming command
  assign cmd_beats = {1'b0, cmd_length_i} + CNT_W'(cmd_offset_i != '0);

  assign line_active_o = (state_q == RUN);
  assign line_rot_o    = rot_q;
  assign beat_first_o  = line_active_o && (cnt_q == '0);
  assign beat_last_o   = line_active_o && (cnt_q == beats_q - CNT_W'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      rot_q   <= '0;
      beats_q <= '0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (cmd_accept) begin
            rot_q   <= cmd_offset_i;
            beats_q <= cmd_beats;
            cnt_q   <= '0;
            state_q <= RUN;
          end
        end
        RUN: begin
          if (beat_take_i) begin
            if (beat_last_o) begin
              // line done, ready for the next command
              cnt_q   <= '0;
              state_q <= IDLE;
            end else begin
              cnt_q <= cnt_q + CNT_W'(1);
            end
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

endmodule : line_sequencer

// ==== rtl/realign_shifter.sv ====
// line_rot_i must hold steady while line_active_i is high; upper bytes of the last beat are dropped

module realign_shifter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                line_active_i,
  input  realign_pkg::off_t   line_rot_i,
  input  logic                beat_first_i,
  input  logic                beat_last_i,
  input  logic                fifo_valid_i,
  output logic                fifo_ready_o,
  input  realign_pkg::word_t  fifo_data_i,
  output logic                beat_take_o,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output realign_pkg::word_t  out_data_o,
  output logic                out_last_o
);

  import realign_pkg::*;

  localparam int unsigned SH_W = $clog2(DATA_W);

  word_t            carry_q;
  word_t            out_data_q;
  logic             out_valid_q;
  logic             out_last_q;
  logic             out_free;
  logic             take;
  logic             complete;
  logic             realign;
  logic [SH_W-1:0]  rot_bits;
  logic [SH_W-1:0]  fill_bits;
  word_t            merged;

  // output register can accept when empty or draining this cycle
  assign out_free = !out_valid_q || out_ready_i;

  assign fifo_ready_o = line_active_i && out_free;
  assign take         = fifo_valid_i && fifo_ready_o;
  assign beat_take_o  = take;

  assign realign = (line_rot_i != '0);

  // bit position of the first valid byte
  assign rot_bits = {line_rot_i, 3'b000};

  // wraps to 64 minus the rotation, only used when realigning
  assign fill_bits = SH_W'(DATA_W) - rot_bits;

  // carry bytes go low, next word's lower bytes fill the top
  always_comb begin
    if (realign) begin
      merged = carry_q | (fifo_data_i << fill_bits);
    end else begin
      merged = fifo_data_i;
    end
  end

  // first beat of a misaligned line only primes the carry
  assign complete = take && (!realign || !beat_first_i);

  // keep bytes from the offset upward, shifted down to byte 0
  always_ff @(posedge clk_i) begin
    if (take) begin
      carry_q <= fifo_data_i >> rot_bits;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
      out_last_q  <= 1'b0;
    end else begin
      if (complete) begin
        out_valid_q <= 1'b1;
        out_last_q  <= beat_last_i;
      end else if (out_ready_i) begin
        out_valid_q <= 1'b0;
        out_last_q  <= 1'b0;
      end
    end
  end

  // payload
  always_ff @(posedge clk_i) begin
    if (complete) begin
      out_data_q <= merged;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;
  assign out_last_o  = out_last_q;

endmodule : realign_shifter

// ==== rtl/source_realign_top.sv ====
// source-side realigner for 64-bit words; FIFO_DEPTH of 2 or more, one line in flight at a time

module source_realign_top #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                cmd_valid_i,
  output logic                cmd_ready_o,
  input  realign_pkg::off_t   cmd_offset_i,
  input  realign_pkg::len_t   cmd_length_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  realign_pkg::word_t  in_data_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output realign_pkg::word_t  out_data_o,
  output logic                out_last_o
);

  import realign_pkg::*;

  logic   fifo_valid;
  logic   fifo_ready;
  word_t  fifo_data;
  logic   line_active;
  off_t   line_rot;
  logic   beat_first;
  logic   beat_last;
  logic   beat_take;

  // elastic buffer for the misaligned input words
  stream_fifo #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) i_fifo (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .push_valid_i ( in_valid_i  ),
    .push_ready_o ( in_ready_o  ),
    .push_data_i  ( in_data_i   ),
    .pop_valid_o  ( fifo_valid  ),
    .pop_ready_i  ( fifo_ready  ),
    .pop_data_o   ( fifo_data   )
  );

  line_sequencer i_sequencer (
    .clk_i         ( clk_i        ),
    .rst_ni        ( rst_ni       ),
    .cmd_valid_i   ( cmd_valid_i  ),
    .cmd_ready_o   ( cmd_ready_o  ),
    .cmd_offset_i  ( cmd_offset_i ),
    .cmd_length_i  ( cmd_length_i ),
    .beat_take_i   ( beat_take    ),
    .line_active_o ( line_active  ),
    .line_rot_o    ( line_rot     ),
    .beat_first_o  ( beat_first   ),
    .beat_last_o   ( beat_last    )
  );

  realign_shifter i_shifter (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .line_active_i ( line_active ),
    .line_rot_i    ( line_rot    ),
    .beat_first_i  ( beat_first  ),
    .beat_last_i   ( beat_last   ),
    .fifo_valid_i  ( fifo_valid  ),
    .fifo_ready_o  ( fifo_ready  ),
    .fifo_data_i   ( fifo_data   ),
    .beat_take_o   ( beat_take   ),
    .out_valid_o   ( out_valid_o ),
    .out_ready_i   ( out_ready_i ),
    .out_data_o    ( out_data_o  ),
    .out_last_o    ( out_last_o  )
  );

endmodule : source_realign_top

// ==== test/realign_model.svh ====
// reference packing for one line; bytes beyond the line end are filled with random values
`ifndef REALIGN_MODEL_SVH
`define REALIGN_MODEL_SVH

  // raw line contents, byte 0 first
  typedef byte unsigned byte_q_t[$];

  // byte k of input word idx carries line byte idx*8 + k - off
  function automatic word_t input_word(byte_q_t bytes, int off, int idx);
    word_t w;
    int    k;
    int    pos;
    for (k = 0; k < STRB_W; k++) begin
      pos = idx * STRB_W + k - off;
      if (pos >= 0 && pos < bytes.size()) begin
        w[k*8 +: 8] = bytes[pos];
      end else begin
        // don't-care byte outside the line
        w[k*8 +: 8] = 8'($urandom);
      end
    end
    return w;
  endfunction

  // aligned output word idx, eight line bytes in order
  function automatic word_t output_word(byte_q_t bytes, int idx);
    word_t w;
    int    k;
    for (k = 0; k < STRB_W; k++) begin
      w[k*8 +: 8] = bytes[idx * STRB_W + k];
    end
    return w;
  endfunction

  // a misaligned line spills into one extra input word
  function automatic int input_beats(int off, int len);
    int beats;
    beats = len;
    if (off != 0) begin
      beats = len + 1;
    end
    return beats;
  endfunction

`endif

// ==== test/tb_source_realign.sv ====
// lines of 1 to 8 words; the mid-run reset is applied only while no line is in flight

module tb_source_realign;

  import realign_pkg::*;

  `include "realign_model.svh"

  localparam int unsigned FIFO_DEPTH = 4;
  localparam int NUM_LINES  = 32;
  localparam int MAX_CYCLES = 40 * NUM_LINES + 200;

  logic   clk_i;
  logic   rst_ni;
  logic   cmd_valid_i;
  logic   cmd_ready_o;
  off_t   cmd_offset_i;
  len_t   cmd_length_i;
  logic   in_valid_i = 1'b0;
  logic   in_ready_o;
  word_t  in_data_i = '0;
  logic   out_valid_o;
  logic   out_ready_i = 1'b1;
  word_t  out_data_o;
  logic   out_last_o;

  word_t  in_q[$];
  word_t  exp_data_q[$];
  logic   exp_last_q[$];
  string  test_name;
  int     errors = 0;
  int     cycles = 0;
  int     ready_low_pct = 0;
  int     gap_pct = 0;
  logic   in_fire = 1'b0;
  int     i;

  source_realign_top #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) uut (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .cmd_valid_i  ( cmd_valid_i  ),
    .cmd_ready_o  ( cmd_ready_o  ),
    .cmd_offset_i ( cmd_offset_i ),
    .cmd_length_i ( cmd_length_i ),
    .in_valid_i   ( in_valid_i   ),
    .in_ready_o   ( in_ready_o   ),
    .in_data_i    ( in_data_i    ),
    .out_valid_o  ( out_valid_o  ),
    .out_ready_i  ( out_ready_i  ),
    .out_data_o   ( out_data_o   ),
    .out_last_o   ( out_last_o   )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // hold reset for two cycles, then look at the idle outputs
  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    if (cmd_ready_o !== 1'b1 || in_ready_o !== 1'b1) begin
      errors++;
      $display("error %s ready: expected 11 actual %b%b", test_name, cmd_ready_o, in_ready_o);
    end
    if (out_valid_o !== 1'b0 || out_last_o !== 1'b0 || uut.line_active !== 1'b0) begin
      errors++;
      $display("error %s idle: expected 000 actual %b%b%b", test_name, out_valid_o,
               out_last_o, uut.line_active);
    end
  endtask

  // queue one random line, then issue its command
  task automatic send_line(input int off, input int len);
    byte_q_t bytes;
    int      n;
    for (n = 0; n < len * STRB_W; n++) begin
      bytes.push_back(8'($urandom));
    end
    for (n = 0; n < input_beats(off, len); n++) begin
      in_q.push_back(input_word(bytes, off, n));
    end
    for (n = 0; n < len; n++) begin
      exp_data_q.push_back(output_word(bytes, n));
      exp_last_q.push_back(n == len - 1);
    end
    cmd_valid_i  = 1'b1;
    cmd_offset_i = off_t'(off);
    cmd_length_i = len_t'(len);
    while (!cmd_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    // the accepted line is now in progress
    if (cmd_ready_o !== 1'b0) begin
      errors++;
      $display("error %s cmd_ready_o: expected 0 actual %b", test_name, cmd_ready_o);
    end
  endtask

  task automatic wait_idle();
    while (exp_data_q.size() != 0 || in_q.size() != 0 || !cmd_ready_o) @(negedge clk_i);
    @(negedge clk_i);
  endtask

  // input words, valid held until taken
  always @(negedge clk_i) begin
    if (in_fire) begin
      void'(in_q.pop_front());
      in_valid_i = 1'b0;
    end
    if (!in_valid_i && in_q.size() != 0 && int'($urandom_range(99)) >= gap_pct) begin
      in_valid_i = 1'b1;
      in_data_i  = in_q[0];
    end
    in_fire = in_valid_i && in_ready_o;
  end

  // scoreboard, a word counts when it will transfer at the next rising edge
  always @(negedge clk_i) begin
    out_ready_i = (int'($urandom_range(99)) >= ready_low_pct);
    if (rst_ni && out_valid_o && out_ready_i) begin
      if (exp_data_q.size() == 0) begin
        errors++;
        $display("unexpected output word %h in test %s", out_data_o, test_name);
      end else begin
        if (out_data_o !== exp_data_q[0]) begin
          errors++;
          $display("error %s data: expected %h actual %h", test_name, exp_data_q[0], out_data_o);
        end
        if (out_last_o !== exp_last_q[0]) begin
          errors++;
          $display("error %s last: expected %b actual %b", test_name, exp_last_q[0], out_last_o);
        end
        void'(exp_data_q.pop_front());
        void'(exp_last_q.pop_front());
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("errors: %0d", errors);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(29418));
    rst_ni       = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_offset_i = '0;
    cmd_length_i = '0;
    test_name    = "reset";
    apply_reset();
    test_name = "zero_offset";
    for (i = 0; i < 4; i++) send_line(0, 1 + int'($urandom_range(7)));
    wait_idle();
    test_name = "random_offset";
    for (i = 0; i < 8; i++) send_line(1 + int'($urandom_range(6)), 1 + int'($urandom_range(7)));
    wait_idle();
    test_name     = "backpressure";
    ready_low_pct = 30;
    for (i = 0; i < 8; i++) send_line(int'($urandom_range(7)), 1 + int'($urandom_range(7)));
    wait_idle();
    test_name = "input_gaps";
    gap_pct   = 30;
    for (i = 0; i < 8; i++) send_line(int'($urandom_range(7)), 1 + int'($urandom_range(7)));
    wait_idle();
    test_name     = "reset_recovery";
    ready_low_pct = 0;
    gap_pct       = 0;
    apply_reset();
    for (i = 0; i < 4; i++) send_line(int'($urandom_range(7)), 1 + int'($urandom_range(7)));
    wait_idle();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : tb_source_realign

// ==== source_realign.f ====
+incdir+test
rtl/realign_pkg.sv
rtl/stream_fifo.sv
rtl/line_sequencer.sv
rtl/realign_shifter.sv
rtl/source_realign_top.sv
test/tb_source_realign.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing
TOP        := tb_source_realign
RTL_TOP    := source_realign_top
FILELIST   := source_realign.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
